// File: hw/lc3b_pkg.sv
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// n, z, p from msb to lsb
	typedef logic [2:0] lc3b_nzp;

	// LC-3b encodings of the opcodes handled here
	typedef enum logic [3:0]
	{
		OP_BR  = 4'b0000,
		OP_ADD = 4'b0001,
		OP_AND = 4'b0101,
		OP_LDR = 4'b0110,
		OP_STR = 4'b0111,
		OP_NOT = 4'b1001
	} lc3b_opcode;

	// one instruction word, three field layouts
	typedef union packed
	{
		// ADD, AND, NOT
		struct packed
		{
			lc3b_opcode opcode;
			lc3b_reg dr;
			lc3b_reg sr1;
			logic imm_flag;
			// sr2 in the low three bits, or imm5
			logic [4:0] sr2_imm5;
		} opr;

		// LDR, STR
		struct packed
		{
			lc3b_opcode opcode;
			lc3b_reg dr_sr;
			lc3b_reg base;
			logic [5:0] offset6;
		} mem;

		// BR
		struct packed
		{
			lc3b_opcode opcode;
			lc3b_nzp nzp;
			logic [8:0] offset9;
		} br;
	} lc3b_instr;

	// write-back source
	typedef enum logic [1:0]
	{
		WB_ALU = 2'b00,
		WB_MEM = 2'b01
	} lc3b_wb_sel;

	// condition codes after reset
	localparam lc3b_nzp NZP_ZERO = 3'b010;

endpackage : lc3b_pkg

// File: hw/lc3b_regfile.sv
`timescale 1ns/1ns

module lc3b_regfile
(
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_reg rd_a_idx,
	input lc3b_pkg::lc3b_reg rd_b_idx,
	output lc3b_pkg::lc3b_word rd_a_data,
	output lc3b_pkg::lc3b_word rd_b_data,
	input logic wr_en,
	input lc3b_pkg::lc3b_reg wr_idx,
	input lc3b_pkg::lc3b_word wr_data
);
	import lc3b_pkg::*;

	lc3b_word regs [8];
	logic wr_ok;

	// no writes while reset is held
	assign wr_ok = wr_en & rst_n;

	always_ff @(posedge clk)
	begin
		if (wr_ok)
			regs[wr_idx] <= wr_data;
	end

	// reads see the old value in the cycle of a write
	assign rd_a_data = regs[rd_a_idx];
	assign rd_b_data = regs[rd_b_idx];

endmodule : lc3b_regfile

// File: hw/lc3b_decode.sv
`timescale 1ns/1ns

module lc3b_decode
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input lc3b_pkg::lc3b_instr instr,
	input lc3b_pkg::lc3b_word instr_pc,
	output lc3b_pkg::lc3b_reg rd_a_idx,
	output lc3b_pkg::lc3b_reg rd_b_idx,
	input lc3b_pkg::lc3b_word rd_a_data,
	input lc3b_pkg::lc3b_word rd_b_data,
	output logic id_valid,
	output logic id_load_regfile,
	output logic id_load_cc,
	output logic id_mem_read,
	output logic id_mem_write,
	output logic id_is_br,
	output lc3b_pkg::lc3b_wb_sel id_wb_sel,
	output lc3b_pkg::lc3b_opcode id_op,
	output lc3b_pkg::lc3b_word id_src_a,
	output lc3b_pkg::lc3b_word id_src_b,
	output lc3b_pkg::lc3b_word id_store_data,
	output lc3b_pkg::lc3b_word id_offset,
	output lc3b_pkg::lc3b_word id_pc,
	output lc3b_pkg::lc3b_reg id_dest,
	output lc3b_pkg::lc3b_nzp id_nzp
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;
	lc3b_word imm5_sext;
	lc3b_word off6_sext;
	lc3b_word off9_sext;
	logic ld_rf;
	logic ld_cc;
	logic m_rd;
	logic m_wr;
	logic is_br;
	lc3b_wb_sel wb_sel;

	assign opcode = instr.opr.opcode;

	// sr1 and base share bits 8:6
	assign rd_a_idx = instr.opr.sr1;
	// STR reads its source register on port b
	assign rd_b_idx = (opcode == OP_STR) ? instr.mem.dr_sr : instr.opr.sr2_imm5[2:0];

	assign imm5_sext = {{11{instr.opr.sr2_imm5[4]}}, instr.opr.sr2_imm5};
	// word offsets become byte offsets
	assign off6_sext = {{9{instr.mem.offset6[5]}}, instr.mem.offset6, 1'b0};
	assign off9_sext = {{6{instr.br.offset9[8]}}, instr.br.offset9, 1'b0};

	always_comb
	begin
		ld_rf = 1'b0;
		ld_cc = 1'b0;
		m_rd = 1'b0;
		m_wr = 1'b0;
		is_br = 1'b0;
		wb_sel = WB_ALU;
		if (instr_valid)
		begin
			case (opcode)
				OP_ADD, OP_AND, OP_NOT:
				begin
					ld_rf = 1'b1;
					ld_cc = 1'b1;
				end
				OP_LDR:
				begin
					ld_rf = 1'b1;
					ld_cc = 1'b1;
					m_rd = 1'b1;
					wb_sel = WB_MEM;
				end
				OP_STR: m_wr = 1'b1;
				OP_BR: is_br = 1'b1;
				default: ld_rf = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			id_valid <= 1'b0;
			id_load_regfile <= 1'b0;
			id_load_cc <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_is_br <= 1'b0;
			id_wb_sel <= WB_ALU;
		end
		else
		begin
			id_valid <= instr_valid;
			id_load_regfile <= ld_rf;
			id_load_cc <= ld_cc;
			id_mem_read <= m_rd;
			id_mem_write <= m_wr;
			id_is_br <= is_br;
			id_wb_sel <= wb_sel;
		end
	end

	// operands and fields
	always_ff @(posedge clk)
	begin
		id_op <= opcode;
		id_src_a <= rd_a_data;
		id_src_b <= instr.opr.imm_flag ? imm5_sext : rd_b_data;
		id_store_data <= rd_b_data;
		id_offset <= (opcode == OP_BR) ? off9_sext : off6_sext;
		id_pc <= instr_pc;
		id_dest <= instr.opr.dr;
		id_nzp <= instr.br.nzp;
	end

endmodule : lc3b_decode

// File: hw/lc3b_execute.sv
`timescale 1ns/1ns

module lc3b_execute
(
	input lc3b_pkg::lc3b_opcode id_op,
	input logic id_is_br,
	input lc3b_pkg::lc3b_word id_src_a,
	input lc3b_pkg::lc3b_word id_src_b,
	input lc3b_pkg::lc3b_word id_offset,
	input lc3b_pkg::lc3b_word id_pc,
	output lc3b_pkg::lc3b_word ex_alu_out,
	output lc3b_pkg::lc3b_word ex_addr_out
);
	import lc3b_pkg::*;

	lc3b_word pc_plus2;
	lc3b_word addr_base;

	// ALU
	always_comb
	begin
		case (id_op)
			OP_ADD: ex_alu_out = id_src_a + id_src_b;
			OP_AND: ex_alu_out = id_src_a & id_src_b;
			OP_NOT: ex_alu_out = ~id_src_a;
			// loads, stores and branches leave the ALU unused
			default: ex_alu_out = id_src_a;
		endcase
	end

	// branch targets are relative to the next instruction
	assign pc_plus2 = id_pc + 16'd2;

	// base register for LDR and STR
	assign addr_base = id_is_br ? pc_plus2 : id_src_a;

	assign ex_addr_out = addr_base + id_offset;

endmodule : lc3b_execute

// File: hw/ex_mem_stage.sv
`timescale 1ns/1ns

module ex_mem_stage
(
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_word alu_out_in,
	input lc3b_pkg::lc3b_word addr_adder_out_in,
	input lc3b_pkg::lc3b_word pc_in,
	input lc3b_pkg::lc3b_word dest_data_in,
	input lc3b_pkg::lc3b_reg dest_in,
	input lc3b_pkg::lc3b_nzp nzp_in,
	input logic valid_in,
	input logic is_br_in,
	input logic load_cc_in,
	input logic load_regfile_in,
	input logic mem_read_in,
	input logic mem_write_in,
	input lc3b_pkg::lc3b_wb_sel regfilemux_sel_in,
	input lc3b_pkg::lc3b_opcode op_in,

	output lc3b_pkg::lc3b_word alu_out_out,
	output lc3b_pkg::lc3b_word addr_adder_out_out,
	output lc3b_pkg::lc3b_word pc_out,
	output lc3b_pkg::lc3b_word dest_data_out,
	output lc3b_pkg::lc3b_reg dest_out,
	output lc3b_pkg::lc3b_nzp nzp_out,
	output logic valid_out,
	output logic is_br_out,
	output logic load_cc_out,
	output logic load_regfile_out,
	output logic mem_read_out,
	output logic mem_write_out,
	output lc3b_pkg::lc3b_wb_sel regfilemux_sel_out,
	output lc3b_pkg::lc3b_opcode op_out
);

	// valid and control
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_out <= 1'b0;
			is_br_out <= 1'b0;
			load_cc_out <= 1'b0;
			load_regfile_out <= 1'b0;
			mem_read_out <= 1'b0;
			mem_write_out <= 1'b0;
		end
		else
		begin
			valid_out <= valid_in;
			is_br_out <= is_br_in;
			load_cc_out <= load_cc_in;
			load_regfile_out <= load_regfile_in;
			mem_read_out <= mem_read_in;
			mem_write_out <= mem_write_in;
		end
	end

	always_ff @(posedge clk)
	begin
		alu_out_out <= alu_out_in;
		addr_adder_out_out <= addr_adder_out_in;
		pc_out <= pc_in;
		dest_data_out <= dest_data_in;
		dest_out <= dest_in;
		nzp_out <= nzp_in;
		regfilemux_sel_out <= regfilemux_sel_in;
		op_out <= op_in;
	end

endmodule : ex_mem_stage

// File: hw/lc3b_result.sv
`timescale 1ns/1ns

module lc3b_result
#(
	parameter int DMEM_WORDS = 256
)
(
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_word alu_out,
	input lc3b_pkg::lc3b_word addr,
	input lc3b_pkg::lc3b_word dest_data,
	input lc3b_pkg::lc3b_reg dest,
	input lc3b_pkg::lc3b_nzp nzp,
	input logic valid,
	input logic is_br,
	input logic load_cc,
	input logic load_regfile,
	input logic mem_read,
	input logic mem_write,
	input lc3b_pkg::lc3b_wb_sel wb_sel,
	input lc3b_pkg::lc3b_opcode op,
	output logic rf_wr_en,
	output lc3b_pkg::lc3b_reg rf_wr_idx,
	output lc3b_pkg::lc3b_word rf_wr_data,
	output logic wb_valid,
	output logic wb_write,
	output logic br_taken,
	output lc3b_pkg::lc3b_opcode wb_op,
	output lc3b_pkg::lc3b_reg wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output lc3b_pkg::lc3b_word br_target,
	output lc3b_pkg::lc3b_nzp cc
);
	import lc3b_pkg::*;

	localparam int AW = $clog2(DMEM_WORDS);

	lc3b_word dmem [DMEM_WORDS];
	logic [AW-1:0] word_idx;
	lc3b_word load_data;
	lc3b_word wb_value;
	lc3b_nzp new_nzp;
	logic br_hit;

	// byte address to word index
	assign word_idx = addr[AW:1];

	always_ff @(posedge clk)
	begin
		if (mem_write)
			dmem[word_idx] <= dest_data;
	end

	assign load_data = mem_read ? dmem[word_idx] : '0;
	assign wb_value = (wb_sel == WB_MEM) ? load_data : alu_out;

	always_comb
	begin
		if (wb_value[15])
			new_nzp = 3'b100;
		else if (wb_value == '0)
			new_nzp = 3'b010;
		else
			new_nzp = 3'b001;
	end

	// tests cc before this instruction's own update
	assign br_hit = is_br & (|(nzp & cc));

	assign rf_wr_en = load_regfile;
	assign rf_wr_idx = dest;
	assign rf_wr_data = wb_value;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cc <= NZP_ZERO;
			wb_valid <= 1'b0;
			wb_write <= 1'b0;
			br_taken <= 1'b0;
		end
		else
		begin
			if (load_cc)
				cc <= new_nzp;
			wb_valid <= valid;
			wb_write <= load_regfile;
			br_taken <= br_hit;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_op <= op;
		wb_dest <= dest;
		// a store reports what it wrote
		wb_data <= mem_write ? dest_data : wb_value;
		br_target <= addr;
	end

endmodule : lc3b_result

// File: hw/lc3b_datapath.sv
`timescale 1ns/1ns

module lc3b_datapath
#(
	parameter int DMEM_WORDS = 256
)
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input lc3b_pkg::lc3b_instr instr,
	input lc3b_pkg::lc3b_word instr_pc,
	output logic wb_valid,
	output lc3b_pkg::lc3b_opcode wb_op,
	output logic wb_write,
	output lc3b_pkg::lc3b_reg wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output lc3b_pkg::lc3b_nzp cc,
	output logic br_taken,
	output lc3b_pkg::lc3b_word br_target
);
	import lc3b_pkg::*;

	// register file
	lc3b_reg rd_a_idx;
	lc3b_reg rd_b_idx;
	lc3b_word rd_a_data;
	lc3b_word rd_b_data;
	logic rf_wr_en;
	lc3b_reg rf_wr_idx;
	lc3b_word rf_wr_data;

	// ID/EX
	logic id_valid;
	logic id_load_regfile;
	logic id_load_cc;
	logic id_mem_read;
	logic id_mem_write;
	logic id_is_br;
	lc3b_wb_sel id_wb_sel;
	lc3b_opcode id_op;
	lc3b_word id_src_a;
	lc3b_word id_src_b;
	lc3b_word id_store_data;
	lc3b_word id_offset;
	lc3b_word id_pc;
	lc3b_reg id_dest;
	lc3b_nzp id_nzp;

	lc3b_word ex_alu_out;
	lc3b_word ex_addr_out;

	// EX/MEM
	lc3b_word mem_alu_out;
	lc3b_word mem_addr;
	lc3b_word mem_dest_data;
	lc3b_reg mem_dest;
	lc3b_nzp mem_nzp;
	logic mem_valid;
	logic mem_is_br;
	logic mem_load_cc;
	logic mem_load_regfile;
	logic mem_rd;
	logic mem_wr;
	lc3b_wb_sel mem_wb_sel;
	lc3b_opcode mem_op;

	lc3b_decode decode_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.rd_a_idx(rd_a_idx),
		.rd_b_idx(rd_b_idx),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.id_valid(id_valid),
		.id_load_regfile(id_load_regfile),
		.id_load_cc(id_load_cc),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_is_br(id_is_br),
		.id_wb_sel(id_wb_sel),
		.id_op(id_op),
		.id_src_a(id_src_a),
		.id_src_b(id_src_b),
		.id_store_data(id_store_data),
		.id_offset(id_offset),
		.id_pc(id_pc),
		.id_dest(id_dest),
		.id_nzp(id_nzp)
	);

	lc3b_regfile regfile_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.rd_a_idx(rd_a_idx),
		.rd_b_idx(rd_b_idx),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.wr_en(rf_wr_en),
		.wr_idx(rf_wr_idx),
		.wr_data(rf_wr_data)
	);

	lc3b_execute execute_i
	(
		.id_op(id_op),
		.id_is_br(id_is_br),
		.id_src_a(id_src_a),
		.id_src_b(id_src_b),
		.id_offset(id_offset),
		.id_pc(id_pc),
		.ex_alu_out(ex_alu_out),
		.ex_addr_out(ex_addr_out)
	);

	// pc is carried for debug visibility only
	ex_mem_stage ex_mem_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.alu_out_in(ex_alu_out),
		.addr_adder_out_in(ex_addr_out),
		.pc_in(id_pc),
		.dest_data_in(id_store_data),
		.dest_in(id_dest),
		.nzp_in(id_nzp),
		.valid_in(id_valid),
		.is_br_in(id_is_br),
		.load_cc_in(id_load_cc),
		.load_regfile_in(id_load_regfile),
		.mem_read_in(id_mem_read),
		.mem_write_in(id_mem_write),
		.regfilemux_sel_in(id_wb_sel),
		.op_in(id_op),
		.alu_out_out(mem_alu_out),
		.addr_adder_out_out(mem_addr),
		.pc_out(),
		.dest_data_out(mem_dest_data),
		.dest_out(mem_dest),
		.nzp_out(mem_nzp),
		.valid_out(mem_valid),
		.is_br_out(mem_is_br),
		.load_cc_out(mem_load_cc),
		.load_regfile_out(mem_load_regfile),
		.mem_read_out(mem_rd),
		.mem_write_out(mem_wr),
		.regfilemux_sel_out(mem_wb_sel),
		.op_out(mem_op)
	);

	lc3b_result
	#(
		.DMEM_WORDS(DMEM_WORDS)
	)
	result_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.alu_out(mem_alu_out),
		.addr(mem_addr),
		.dest_data(mem_dest_data),
		.dest(mem_dest),
		.nzp(mem_nzp),
		.valid(mem_valid),
		.is_br(mem_is_br),
		.load_cc(mem_load_cc),
		.load_regfile(mem_load_regfile),
		.mem_read(mem_rd),
		.mem_write(mem_wr),
		.wb_sel(mem_wb_sel),
		.op(mem_op),
		.rf_wr_en(rf_wr_en),
		.rf_wr_idx(rf_wr_idx),
		.rf_wr_data(rf_wr_data),
		.wb_valid(wb_valid),
		.wb_write(wb_write),
		.br_taken(br_taken),
		.wb_op(wb_op),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.br_target(br_target),
		.cc(cc)
	);

endmodule : lc3b_datapath

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
#(
	parameter int PERIOD_NS = 40
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

endmodule : tb_clock

// File: sim/tb_lc3b_datapath.sv
`timescale 1ns/1ns

module tb_lc3b_datapath;
	import lc3b_pkg::*;

	localparam int PERIOD_NS = 40;
	// reset, sixteen setup instructions and six idle cycles
	localparam int SETUP_CYCLES = 25;
	localparam int RANDOM_CYCLES = 400;
	localparam int WATCHDOG_NS = (SETUP_CYCLES + RANDOM_CYCLES + 20) * PERIOD_NS;

	logic clk;
	logic rst_n;
	logic instr_valid;
	lc3b_instr instr;
	lc3b_word instr_pc;
	logic wb_valid;
	lc3b_opcode wb_op;
	logic wb_write;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_nzp cc;
	logic br_taken;
	lc3b_word br_target;

	logic [31:0] lfsr;
	int cycle;
	logic checking;
	lc3b_word next_pc;

	// reference model state
	lc3b_word regs [8];
	lc3b_nzp model_cc;
	lc3b_word model_mem [lc3b_word];
	// offsets from R0 that a store has already covered
	logic stored [64];
	// pending register writes with the newest at index 0
	logic pend_we [3];
	lc3b_reg pend_idx [3];
	lc3b_word pend_data [3];

	// expected retirements in issue order
	int exp_due [$];
	logic [3:0] exp_op [$];
	logic exp_write [$];
	lc3b_reg exp_dest [$];
	lc3b_word exp_data [$];
	lc3b_nzp exp_cc [$];
	logic exp_is_br [$];
	logic exp_taken [$];
	lc3b_word exp_target [$];

	tb_clock #(.PERIOD_NS(PERIOD_NS)) clock_i (.clk(clk));

	lc3b_datapath
	#(
		.DMEM_WORDS(256)
	)
	dut_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.wb_valid(wb_valid),
		.wb_op(wb_op),
		.wb_write(wb_write),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.cc(cc),
		.br_taken(br_taken),
		.br_target(br_target)
	);

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] bits;
		logic fb;
		int i;
		bits = '0;
		for (i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[14:0], fb};
		end
		return bits;
	endfunction

	function automatic lc3b_nzp nzp_of(input lc3b_word v);
		if (v[15])
			return 3'b100;
		else if (v == 16'd0)
			return 3'b010;
		return 3'b001;
	endfunction

	function automatic lc3b_word sext5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// makes writes issued three cycles ago visible
	task automatic commit_pending();
		if (pend_we[2])
			regs[pend_idx[2]] = pend_data[2];
		pend_we[2] = pend_we[1];
		pend_idx[2] = pend_idx[1];
		pend_data[2] = pend_data[1];
		pend_we[1] = pend_we[0];
		pend_idx[1] = pend_idx[0];
		pend_data[1] = pend_data[0];
		pend_we[0] = 1'b0;
	endtask

	task automatic predict_result(input logic [15:0] iw, input lc3b_word pc);
		logic [3:0] op;
		lc3b_word a;
		lc3b_word b;
		lc3b_word addr;
		lc3b_word value;
		logic writes;
		logic taken;
		op = iw[15:12];
		a = regs[iw[8:6]];
		b = iw[5] ? sext5(iw[4:0]) : regs[iw[2:0]];
		addr = a + {{9{iw[5]}}, iw[5:0], 1'b0};
		value = '0;
		writes = 1'b0;
		taken = 1'b0;
		case (op)
			OP_ADD:
			begin
				value = a + b;
				writes = 1'b1;
			end
			OP_AND:
			begin
				value = a & b;
				writes = 1'b1;
			end
			OP_NOT:
			begin
				value = ~a;
				writes = 1'b1;
			end
			OP_LDR:
			begin
				value = model_mem[addr];
				writes = 1'b1;
			end
			OP_STR:
			begin
				value = regs[iw[11:9]];
				model_mem[addr] = value;
			end
			default:
			begin
				taken = |(iw[11:9] & model_cc);
				addr = pc + 16'd2 + {{6{iw[8]}}, iw[8:0], 1'b0};
			end
		endcase
		if (writes)
		begin
			model_cc = nzp_of(value);
			pend_we[0] = 1'b1;
			pend_idx[0] = iw[11:9];
			pend_data[0] = value;
		end
		exp_due.push_back(cycle + 3);
		exp_op.push_back(op);
		exp_write.push_back(writes);
		exp_dest.push_back(iw[11:9]);
		exp_data.push_back(value);
		exp_cc.push_back(model_cc);
		exp_is_br.push_back(op == OP_BR);
		exp_taken.push_back(taken);
		exp_target.push_back(addr);
	endtask

	function automatic logic [15:0] operate_word(input logic [3:0] op, input lc3b_reg dr);
		lc3b_reg sr1;
		sr1 = 3'(rand_bits(3));
		if (rand_bits(1) != 16'd0)
			return {op, dr, sr1, 1'b1, 5'(rand_bits(5))};
		return {op, dr, sr1, 3'b000, 3'(rand_bits(3))};
	endfunction

	// R0 stays zero so loads and stores use it as base
	task automatic make_random_instr(output logic [15:0] iw);
		logic [2:0] kind;
		lc3b_reg dr;
		logic [5:0] off;
		kind = 3'(rand_bits(3));
		dr = 3'(rand_bits(3));
		if (dr == 3'd0)
			dr = 3'd7;
		off = 6'(rand_bits(6));
		case (kind)
			3'd0, 3'd1: iw = operate_word(OP_ADD, dr);
			3'd2: iw = operate_word(OP_AND, dr);
			3'd3: iw = {OP_NOT, dr, 3'(rand_bits(3)), 6'b111111};
			3'd4, 3'd5:
			begin
				// a load from an address nobody stored to becomes a store
				if (kind == 3'd4 && stored[off])
					iw = {OP_LDR, dr, 3'd0, off};
				else
				begin
					iw = {OP_STR, 3'(rand_bits(3)), 3'd0, off};
					stored[off] = 1'b1;
				end
			end
			default: iw = {OP_BR, 3'(rand_bits(3)), 9'(rand_bits(9))};
		endcase
	endtask

	task automatic step_cycle(input logic valid, input logic [15:0] iw);
		@(posedge clk);
		cycle = cycle + 1;
		instr_valid <= valid;
		instr <= iw;
		instr_pc <= next_pc;
		commit_pending();
		if (valid)
		begin
			predict_result(iw, next_pc);
			next_pc = next_pc + 16'd2;
		end
	endtask

	task automatic check_retire();
		logic is_br;
		logic wr;
		lc3b_word data;
		lc3b_word target;
		void'(exp_due.pop_front());
		is_br = exp_is_br.pop_front();
		wr = exp_write.pop_front();
		data = exp_data.pop_front();
		target = exp_target.pop_front();
		check_value("wb_valid", 16'(wb_valid), 16'd1);
		check_value("wb_op", 16'(wb_op), 16'(exp_op.pop_front()));
		check_value("wb_write", 16'(wb_write), 16'(wr));
		check_value("cc", 16'(cc), 16'(exp_cc.pop_front()));
		check_value("br_taken", 16'(br_taken), 16'(exp_taken.pop_front()));
		if (wr)
			check_value("wb_dest", 16'(wb_dest), 16'(exp_dest[0]));
		void'(exp_dest.pop_front());
		if (is_br)
			check_value("br_target", br_target, target);
		else
			check_value("wb_data", wb_data, data);
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (checking)
		begin
			if (exp_due.size() > 0 && exp_due[0] == cycle)
				check_retire();
			else
			begin
				check_value("wb_valid", 16'(wb_valid), 16'd0);
				check_value("wb_write", 16'(wb_write), 16'd0);
				check_value("br_taken", 16'(br_taken), 16'd0);
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Error: the run did not finish within %0d ns", WATCHDOG_NS);
		stop_with_failure();
	end

	initial
	begin
		int i;
		logic [15:0] iw;
		logic [4:0] imm;
		lfsr = 32'h08cd11df;
		cycle = 0;
		checking = 1'b0;
		next_pc = 16'h3000;
		model_cc = 3'b010;
		for (i = 0; i < 8; i++)
			regs[i] = '0;
		for (i = 0; i < 64; i++)
			stored[i] = 1'b0;
		for (i = 0; i < 3; i++)
			pend_we[i] = 1'b0;
		rst_n <= 1'b0;
		instr_valid <= 1'b0;
		instr <= '0;
		instr_pc <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		checking = 1'b1;
		@(negedge clk);
		check_value("cc", 16'(cc), 16'(3'b010));

		// clear all registers then load small constants with R0 left at zero
		for (i = 0; i < 8; i++)
			step_cycle(1'b1, {OP_AND, 3'(i), 3'(i), 1'b1, 5'd0});
		for (i = 0; i < 8; i++)
		begin
			imm = (i == 0) ? 5'd0 : 5'(rand_bits(5));
			step_cycle(1'b1, {OP_ADD, 3'(i), 3'(i), 1'b1, imm});
		end
		repeat (6) step_cycle(1'b0, 16'h0000);

		// valid three times in four
		for (i = 0; i < RANDOM_CYCLES; i++)
		begin
			if (2'(rand_bits(2)) != 2'd0)
			begin
				make_random_instr(iw);
				step_cycle(1'b1, iw);
			end
			else
				step_cycle(1'b0, 16'h0000);
		end
		repeat (6) step_cycle(1'b0, 16'h0000);

		$display("Result: PASSED");
		$finish;
	end

endmodule : tb_lc3b_datapath

// File: vlog.f
hw/lc3b_pkg.sv
hw/lc3b_regfile.sv
hw/lc3b_decode.sv
hw/lc3b_execute.sv
hw/ex_mem_stage.sv
hw/lc3b_result.sv
hw/lc3b_datapath.sv
sim/tb_clock.sv
sim/tb_lc3b_datapath.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= tb_lc3b_datapath
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
